// ==== common/cpu_pkg.sv ====
package cpu_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and fixed values
	//////////////////////////////////////////////////////////////////////
	localparam int word_w    = 16;
	localparam int reg_idx_w = 4;
	localparam int num_regs  = 16;

	typedef logic [word_w-1:0]    word_t;
	typedef logic [reg_idx_w-1:0] reg_idx_t;

	// Execution starts at the bottom of instruction memory
	localparam word_t reset_pc = 16'h0000;

	//////////////////////////////////////////////////////////////////////
	// Instruction set encodings
	//////////////////////////////////////////////////////////////////////
	// Opcode in instr[15:12], all-zero word doubles as NOP
	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_AND = 4'h2,
		OP_NOR = 4'h3,
		OP_SLL = 4'h4,
		OP_SRL = 4'h5,
		OP_SRA = 4'h6,
		OP_LW  = 4'h8,
		OP_SW  = 4'h9,
		OP_LHB = 4'ha,
		OP_LLB = 4'hb,
		OP_B   = 4'hc,
		OP_HLT = 4'hf
	} opcode_e;

	// Branch condition in instr[11:9]
	typedef enum logic [2:0] {
		COND_NE = 3'd0,
		COND_EQ = 3'd1,
		COND_GT = 3'd2,
		COND_LT = 3'd3,
		COND_GE = 3'd4,
		COND_LE = 3'd5,
		COND_OV = 3'd6,
		COND_UN = 3'd7
	} cond_e;

	// ALU function, byte insert covers both LLB and LHB
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_NOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_BYT
	} alu_op_e;

	typedef struct packed {
		logic n;
		logic z;
		logic v;
	} flags_t;

	//////////////////////////////////////////////////////////////////////
	// Stage payloads, all-zero is a bubble
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		word_t instr;
		word_t pc;
	} if_id_t;

	typedef struct packed {
		logic     valid;
		alu_op_e  alu_op;
		word_t    src_a;
		word_t    src_b;
		word_t    imm;
		logic [3:0] shamt;
		reg_idx_t rd;
		logic     set_nzv;
		logic     set_z;
		logic     mem_we;
		logic     mem_re;
		logic     reg_we;
		logic     halt;
	} id_ex_t;

	typedef struct packed {
		logic     valid;
		word_t    result;
		word_t    store_data;
		reg_idx_t rd;
		logic     mem_we;
		logic     mem_re;
		logic     reg_we;
		logic     halt;
	} ex_mem_t;

	typedef struct packed {
		logic     valid;
		word_t    alu_result;
		word_t    load_data;
		reg_idx_t rd;
		logic     wb_sel;
		logic     reg_we;
		logic     halt;
	} mem_wb_t;

endpackage

// ==== logic/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     stall,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// Flush wins over load, stall keeps the old payload
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// Bubble after reset
			q <= '0;
		end else if (flush) begin
			q <= '0;
		end else if (!stall) begin
			q <= d;
		end
	end

	// Hold and kill of the same stage are never requested together
	stall_flush_excl: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(stall && flush)
	);

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   stall,
	input  logic   halt_seen,
	input  logic   branch_taken,
	input  word_t  branch_target,
	input  word_t  imem_data,
	output word_t  imem_addr,
	output if_id_t if_id
);

	word_t pc_q;
	word_t pc_d;
	logic  halted_q;
	logic  squash;

	// Wrong-path word after a taken branch, or anything past HLT
	assign squash = branch_taken || halt_seen || halted_q;

	// Next PC, stall has priority since the branch may see stale flags
	always_comb begin
		if (stall || halt_seen || halted_q) begin
			pc_d = pc_q;
		end else if (branch_taken) begin
			pc_d = branch_target;
		end else begin
			pc_d = pc_q + 16'd1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q     <= reset_pc;
			halted_q <= 1'b0;
		end else begin
			pc_q     <= pc_d;
			// Sticky until reset
			halted_q <= halted_q || halt_seen;
		end
	end

	assign imem_addr = pc_q;
	assign if_id     = squash ? if_id_t'('0) : if_id_t'{instr: imem_data, pc: pc_q};

endmodule

// ==== decode/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  reg_idx_t rs,
	input  reg_idx_t rt,
	input  logic     we,
	input  reg_idx_t wd_addr,
	input  word_t    wd,
	output word_t    rs_data,
	output word_t    rt_data
);

	word_t regs [num_regs];

	// Single write port, written at the end of writeback
	always_ff @(posedge clk) begin
		if (we) begin
			regs[wd_addr] <= wd;
		end
	end

	// r0 hardwired to zero
	// Same-cycle write shows through so decode never waits an extra cycle
	assign rs_data = (rs == '0) ? '0 : (we && wd_addr == rs) ? wd : regs[rs];
	assign rt_data = (rt == '0) ? '0 : (we && wd_addr == rt) ? wd : regs[rt];

	// Decode drops reg_we for rd of zero, so r0 is never targeted
	no_r0_write: assert property (
		@(posedge clk) disable iff (!arst_n)
		we |-> (wd_addr != '0)
	);

endmodule

// ==== decode/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit import cpu_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  if_id_t   if_id,
	input  mem_wb_t  mem_wb,
	input  flags_t   flags,
	output id_ex_t   id_ex,
	output logic     branch_taken,
	output word_t    branch_target,
	output logic     halt_seen,
	output reg_idx_t src_rs,
	output reg_idx_t src_rt,
	output logic     uses_rs,
	output logic     uses_rt,
	output logic     is_branch,
	output logic     hlt
);

	opcode_e  op;
	reg_idx_t rd;
	cond_e    cond;
	logic     is_rtype;
	logic     is_shift;
	logic     is_mem;
	logic     is_byte;
	logic     cond_met;
	word_t    rs_data;
	word_t    rt_data;
	word_t    wb_data;
	logic     wb_we;

	//////////////////////////////////////////////////////////////////////
	// Field split and instruction class
	//////////////////////////////////////////////////////////////////////
	assign op   = opcode_e'(if_id.instr[15:12]);
	assign rd   = if_id.instr[11:8];
	assign cond = cond_e'(if_id.instr[11:9]);

	assign is_rtype = op inside {OP_ADD, OP_SUB, OP_AND, OP_NOR};
	assign is_shift = op inside {OP_SLL, OP_SRL, OP_SRA};
	assign is_mem   = op inside {OP_LW, OP_SW};
	assign is_byte  = op inside {OP_LLB, OP_LHB};

	// Byte loads merge into old rd, stores read data from rd
	assign src_rs  = is_byte ? rd : if_id.instr[7:4];
	assign src_rt  = (op == OP_SW) ? rd : if_id.instr[3:0];
	assign uses_rs = is_rtype || is_shift || is_mem || is_byte;
	assign uses_rt = is_rtype || (op == OP_SW);

	//////////////////////////////////////////////////////////////////////
	// Control bundle for execute
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		id_ex = '0;
		// NOP and bubbles are the zero word
		id_ex.valid = |if_id.instr;
		case (op)
			OP_SUB:         id_ex.alu_op = ALU_SUB;
			OP_AND:         id_ex.alu_op = ALU_AND;
			OP_NOR:         id_ex.alu_op = ALU_NOR;
			OP_SLL:         id_ex.alu_op = ALU_SLL;
			OP_SRL:         id_ex.alu_op = ALU_SRL;
			OP_SRA:         id_ex.alu_op = ALU_SRA;
			OP_LLB, OP_LHB: id_ex.alu_op = ALU_BYT;
			default:        id_ex.alu_op = ALU_ADD;
		endcase
		id_ex.src_a = rs_data;
		id_ex.src_b = rt_data;
		// 8-bit byte immediate or sign-extended 4-bit offset
		id_ex.imm = is_byte ? {8'h00, if_id.instr[7:0]} : {{12{if_id.instr[3]}}, if_id.instr[3:0]};
		// Byte position doubles as shift amount, 8 for the high byte
		if (is_byte) begin
			id_ex.shamt = (op == OP_LHB) ? 4'd8 : 4'd0;
		end else begin
			id_ex.shamt = if_id.instr[3:0];
		end
		id_ex.rd      = rd;
		id_ex.set_nzv = op inside {OP_ADD, OP_SUB};
		id_ex.set_z   = is_shift || (op inside {OP_AND, OP_NOR});
		id_ex.mem_we  = (op == OP_SW);
		id_ex.mem_re  = (op == OP_LW);
		id_ex.reg_we  = (is_rtype || is_shift || is_byte || op == OP_LW) && id_ex.valid
			&& (rd != '0);
		id_ex.halt    = (op == OP_HLT);
	end

	//////////////////////////////////////////////////////////////////////
	// Branch resolve
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (cond)
			COND_NE: cond_met = !flags.z;
			COND_EQ: cond_met = flags.z;
			COND_GT: cond_met = !flags.z && !flags.n;
			COND_LT: cond_met = flags.n;
			COND_GE: cond_met = flags.z || !flags.n;
			COND_LE: cond_met = flags.n || flags.z;
			COND_OV: cond_met = flags.v;
			COND_UN: cond_met = 1'b1;
		endcase
	end

	assign is_branch     = (op == OP_B);
	assign branch_taken  = is_branch && cond_met;
	// Word offset relative to PC+1
	assign branch_target = if_id.pc + 16'd1 + {{7{if_id.instr[8]}}, if_id.instr[8:0]};
	assign halt_seen     = (op == OP_HLT);

	//////////////////////////////////////////////////////////////////////
	// Writeback and register file
	//////////////////////////////////////////////////////////////////////
	assign wb_data = mem_wb.wb_sel ? mem_wb.load_data : mem_wb.alu_result;
	assign wb_we   = mem_wb.valid && mem_wb.reg_we;

	reg_file u_reg_file (
		.clk     (clk),
		.arst_n  (arst_n),
		.rs      (src_rs),
		.rt      (src_rt),
		.we      (wb_we),
		.wd_addr (mem_wb.rd),
		.wd      (wb_data),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	// Halt flag, set as HLT retires
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hlt <= 1'b0;
		end else if (mem_wb.valid && mem_wb.halt) begin
			hlt <= 1'b1;
		end
	end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  id_ex_t  id_ex,
	output ex_mem_t ex_mem,
	output flags_t  flags
);

	word_t  op_a;
	word_t  op_b;
	word_t  sum;
	word_t  diff;
	word_t  byte_mask;
	word_t  result;
	logic   add_ovf;
	logic   sub_ovf;
	flags_t flags_d;

	assign op_a = id_ex.src_a;
	// Loads and stores add the offset, src_b then carries store data
	assign op_b = (id_ex.mem_we || id_ex.mem_re) ? id_ex.imm : id_ex.src_b;

	// Wrapping add and subtract
	assign sum  = op_a + op_b;
	assign diff = op_a - op_b;
	// Signed overflow from sign bits
	assign add_ovf = (op_a[15] == op_b[15]) && (sum[15] != op_a[15]);
	assign sub_ovf = (op_a[15] != op_b[15]) && (diff[15] != op_a[15]);

	// Byte lane being replaced by LLB or LHB
	assign byte_mask = 16'h00ff << id_ex.shamt;

	always_comb begin
		case (id_ex.alu_op)
			ALU_ADD: result = sum;
			ALU_SUB: result = diff;
			ALU_AND: result = op_a & op_b;
			ALU_NOR: result = ~(op_a | op_b);
			ALU_SLL: result = op_a << id_ex.shamt;
			ALU_SRL: result = op_a >> id_ex.shamt;
			ALU_SRA: result = word_t'($signed(op_a) >>> id_ex.shamt);
			// Keep other byte of old rd
			ALU_BYT: result = (op_a & ~byte_mask) | (id_ex.imm << id_ex.shamt);
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Flag register
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		flags_d = flags;
		if (id_ex.valid && id_ex.set_nzv) begin
			flags_d.n = result[15];
			flags_d.z = (result == '0);
			flags_d.v = (id_ex.alu_op == ALU_SUB) ? sub_ovf : add_ovf;
		end else if (id_ex.valid && id_ex.set_z) begin
			// Logic and shifts touch Z only
			flags_d.z = (result == '0);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
		end else begin
			flags <= flags_d;
		end
	end

	// Result plus the pass-through controls for memory and writeback
	assign ex_mem = ex_mem_t'{
		valid:      id_ex.valid,
		result:     result,
		store_data: id_ex.src_b,
		rd:         id_ex.rd,
		mem_we:     id_ex.mem_we,
		mem_re:     id_ex.mem_re,
		reg_we:     id_ex.reg_we,
		halt:       id_ex.halt
	};

endmodule

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
	input  reg_idx_t src_rs,
	input  reg_idx_t src_rt,
	input  logic     uses_rs,
	input  logic     uses_rt,
	input  logic     is_branch,
	input  id_ex_t   id_ex,
	input  ex_mem_t  ex_mem,
	output logic     stall
);

	logic rs_live;
	logic rt_live;
	logic ex_wr;
	logic mem_wr;
	logic raw_ex;
	logic raw_mem;
	logic flag_hz;

	// r0 never carries a dependency
	assign rs_live = uses_rs && (src_rs != '0);
	assign rt_live = uses_rt && (src_rt != '0);

	// Producers still in flight
	assign ex_wr  = id_ex.valid && id_ex.reg_we;
	assign mem_wr = ex_mem.valid && ex_mem.reg_we;

	// Read after write, no forwarding so wait for writeback bypass
	assign raw_ex  = ex_wr && ((rs_live && src_rs == id_ex.rd) || (rt_live && src_rt == id_ex.rd));
	assign raw_mem = mem_wr
		&& ((rs_live && src_rs == ex_mem.rd) || (rt_live && src_rt == ex_mem.rd));

	// Flags update at end of execute
	assign flag_hz = is_branch && id_ex.valid && (id_ex.set_nzv || id_ex.set_z);

	assign stall = raw_ex || raw_mem || flag_hz;

endmodule

// ==== logic/cpu.sv ====
`timescale 1ns/1ps

module cpu import cpu_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  word_t imem_data,
	input  word_t dmem_rdata,
	output word_t imem_addr,
	output word_t dmem_addr,
	output word_t dmem_wdata,
	output logic  dmem_we,
	output logic  hlt
);

	// Stage payloads, _d into the flop and _q out of it
	if_id_t   if_id_d;
	if_id_t   if_id_q;
	id_ex_t   id_ex_d;
	id_ex_t   id_ex_q;
	ex_mem_t  ex_mem_d;
	ex_mem_t  ex_mem_q;
	mem_wb_t  mem_wb_d;
	mem_wb_t  mem_wb_q;

	// Decode to fetch and hazard
	flags_t   flags;
	logic     stall;
	logic     branch_taken;
	word_t    branch_target;
	logic     halt_seen;
	reg_idx_t src_rs;
	reg_idx_t src_rt;
	logic     uses_rs;
	logic     uses_rt;
	logic     is_branch;

	// Fetch
	fetch_unit u_fetch (
		.clk           (clk),
		.arst_n        (arst_n),
		.stall         (stall),
		.halt_seen     (halt_seen),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.imem_data     (imem_data),
		.imem_addr     (imem_addr),
		.if_id         (if_id_d)
	);

	// IF_ID, wrong-path word already squashed by fetch
	pipe_reg #(.payload_t(if_id_t)) u_if_id (
		.clk(clk), .arst_n(arst_n), .stall(stall), .flush(1'b0), .d(if_id_d), .q(if_id_q)
	);

	//////////////////////////////////////////////////////////////////////
	// Decode with hazard check beside it
	//////////////////////////////////////////////////////////////////////
	decode_unit u_decode (
		.clk           (clk),
		.arst_n        (arst_n),
		.if_id         (if_id_q),
		.mem_wb        (mem_wb_q),
		.flags         (flags),
		.id_ex         (id_ex_d),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.halt_seen     (halt_seen),
		.src_rs        (src_rs),
		.src_rt        (src_rt),
		.uses_rs       (uses_rs),
		.uses_rt       (uses_rt),
		.is_branch     (is_branch),
		.hlt           (hlt)
	);

	hazard_unit u_hazard (
		.src_rs    (src_rs),
		.src_rt    (src_rt),
		.uses_rs   (uses_rs),
		.uses_rt   (uses_rt),
		.is_branch (is_branch),
		.id_ex     (id_ex_q),
		.ex_mem    (ex_mem_q),
		.stall     (stall)
	);

	// ID_EX, stall inserts a bubble
	pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
		.clk(clk), .arst_n(arst_n), .stall(1'b0), .flush(stall), .d(id_ex_d), .q(id_ex_q)
	);

	//////////////////////////////////////////////////////////////////////
	// Execute, memory, writeback
	//////////////////////////////////////////////////////////////////////
	alu u_alu (
		.clk    (clk),
		.arst_n (arst_n),
		.id_ex  (id_ex_q),
		.ex_mem (ex_mem_d),
		.flags  (flags)
	);

	pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
		.clk(clk), .arst_n(arst_n), .stall(1'b0), .flush(1'b0), .d(ex_mem_d), .q(ex_mem_q)
	);

	// Data port straight off EX_MEM
	assign dmem_addr  = ex_mem_q.result;
	assign dmem_wdata = ex_mem_q.store_data;
	assign dmem_we    = ex_mem_q.mem_we;

	// Load data joins the result, loads pick it at writeback
	assign mem_wb_d = mem_wb_t'{
		valid:      ex_mem_q.valid,
		alu_result: ex_mem_q.result,
		load_data:  dmem_rdata,
		rd:         ex_mem_q.rd,
		wb_sel:     ex_mem_q.mem_re,
		reg_we:     ex_mem_q.reg_we,
		halt:       ex_mem_q.halt
	};

	pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
		.clk(clk), .arst_n(arst_n), .stall(1'b0), .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q)
	);

endmodule

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

	logic  clk;
	logic  arst_n;
	word_t imem_data;
	word_t imem_addr;
	word_t dmem_rdata;
	word_t dmem_addr;
	word_t dmem_wdata;
	logic  dmem_we;
	logic  hlt;

	// Memories, program and data
	word_t prog [512];
	word_t dmem [1024];

	// Program under construction, expected and observed stores
	word_t prog_q [$];
	word_t exp_addr [$];
	word_t exp_data [$];
	word_t log_addr [$];
	word_t log_data [$];

	word_t lfsr_state  = 16'd75;
	int    total_len   = 0;
	int    cycle_limit = 100;
	int    run_cycles  = 0;
	int    pass_count  = 0;
	int    fail_count  = 0;
	int    err_count   = 0;

	cpu u_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.imem_data  (imem_data),
		.dmem_rdata (dmem_rdata),
		.imem_addr  (imem_addr),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.hlt        (hlt)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Both memories answer in the same cycle
	assign imem_data  = prog[imem_addr[8:0]];
	assign dmem_rdata = dmem[dmem_addr[9:0]];

	// Store capture mid-cycle, outputs settled
	always @(negedge clk) begin
		if (arst_n && dmem_we) begin
			log_addr.push_back(dmem_addr);
			log_data.push_back(dmem_wdata);
			dmem[dmem_addr[9:0]] = dmem_wdata;
		end
	end

	// Watchdog over running cycles only
	always @(negedge clk) begin
		if (arst_n && !hlt) begin
			run_cycles++;
			if (run_cycles > cycle_limit) begin
				$display("Timeout: processor did not halt within %0d cycles", cycle_limit);
				$display("Test failed");
				$finish;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////
	// Galois LFSR, taps x^16+x^14+x^13+x^11+1
	function automatic word_t take_bits(int n);
		word_t r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[14:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
		end
		return r;
	endfunction

	// Preload pattern, every address bit matters
	function automatic word_t fill_word(int unsigned a);
		return word_t'((a * 37) ^ (a << 9) ^ 16'h6b2d);
	endfunction

	// N, Z, V as {n, z, v} from full-width signed math
	function automatic logic [2:0] arith_flags(word_t a, word_t b, bit sub);
		int    sa;
		int    sb;
		int    full;
		word_t r;
		sa   = $signed(a);
		sb   = $signed(b);
		full = sub ? (sa - sb) : (sa + sb);
		r    = full[15:0];
		return {r[15], r == 16'h0000, (full > 32767) || (full < -32768)};
	endfunction

	function automatic bit cond_holds(int c, logic [2:0] f);
		case (c)
			0: return !f[1];
			1: return f[1];
			2: return !f[1] && !f[2];
			3: return f[2];
			4: return !f[2];
			5: return f[2] || f[1];
			6: return f[0];
			default: return 1'b1;
		endcase
	endfunction

	task automatic emit_op(opcode_e op, int rd, int rs, int rt);
		prog_q.push_back({4'(op), 4'(rd), 4'(rs), 4'(rt)});
	endtask

	task automatic emit_branch(int c, int off);
		prog_q.push_back({4'(OP_B), 3'(c), 9'(off)});
	endtask

	// Low byte first, LHB then keeps it
	task automatic ld_const(int rd, word_t v);
		emit_op(OP_LLB, rd, v[7:4], v[3:0]);
		emit_op(OP_LHB, rd, v[15:12], v[11:8]);
	endtask

	// r14 holds the store address
	task automatic store_reg(int rv, word_t addr, word_t val);
		ld_const(14, addr);
		emit_op(OP_SW, rv, 14, 0);
		exp_addr.push_back(addr);
		exp_data.push_back(val);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Run one program and compare the store log
	//////////////////////////////////////////////////////////////////////
	task automatic run_test(string name, int hold);
		int    errs;
		int    n;
		word_t park_pc;
		errs = 0;
		total_len += prog_q.size();
		cycle_limit = total_len * 5 + 100;
		// Fetch stops one word past the first HLT
		park_pc = '0;
		for (int i = prog_q.size() - 1; i >= 0; i--) begin
			if (prog_q[i][15:12] == OP_HLT) begin
				park_pc = word_t'(i + 1);
			end
		end
		@(posedge clk);
		arst_n <= 1'b0;
		@(negedge clk);
		for (int i = 0; i < 512; i++) begin
			prog[i] = (i < prog_q.size()) ? prog_q[i] : 16'h0000;
		end
		for (int i = 0; i < 1024; i++) begin
			dmem[i] = fill_word(i);
		end
		log_addr.delete();
		log_data.delete();
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		while (!hlt) @(negedge clk);
		if (imem_addr !== park_pc) begin
			$display("[ERROR] %0t imem_addr: expected %h, got %h", $time, park_pc, imem_addr);
			errs++;
		end
		// hlt is sticky, fetch stays parked
		repeat (hold) begin
			@(negedge clk);
			if (hlt !== 1'b1) begin
				$display("[ERROR] %0t hlt: expected 1, got %b", $time, hlt);
				errs++;
			end
			if (imem_addr !== park_pc) begin
				$display("[ERROR] %0t imem_addr: expected %h, got %h", $time, park_pc,
					imem_addr);
				errs++;
			end
		end
		n = (log_addr.size() < exp_addr.size()) ? log_addr.size() : exp_addr.size();
		for (int i = 0; i < n; i++) begin
			if (log_addr[i] !== exp_addr[i]) begin
				$display("[ERROR] %0t dmem_addr (store %0d): expected %h, got %h",
					$time, i, exp_addr[i], log_addr[i]);
				errs++;
			end
			if (log_data[i] !== exp_data[i]) begin
				$display("[ERROR] %0t dmem_wdata (store %0d): expected %h, got %h",
					$time, i, exp_data[i], log_data[i]);
				errs++;
			end
		end
		if (log_addr.size() < exp_addr.size()) begin
			$display("%s: %0d expected stores never happened", name,
				exp_addr.size() - log_addr.size());
			errs++;
		end
		if (log_addr.size() > exp_addr.size()) begin
			$display("%s: %0d stores happened that were not expected", name,
				log_addr.size() - exp_addr.size());
			errs++;
		end
		$display("%s: %s, %0d stores, %0d errors", name, (errs == 0) ? "ok" : "FAILED",
			log_addr.size(), errs);
		if (errs == 0) begin
			pass_count++;
		end else begin
			fail_count++;
		end
		err_count += errs;
		prog_q.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////
	// Each result feeds the next, so every step stalls
	task automatic test_alu_ops();
		word_t a;
		word_t b;
		word_t s;
		word_t d;
		word_t an;
		word_t no;
		a  = 16'h1234;
		b  = 16'h0ff0;
		s  = a + b;
		d  = a - s;
		an = d & b;
		no = ~(an | a);
		ld_const(1, a);
		ld_const(2, b);
		emit_op(OP_ADD, 3, 1, 2);
		emit_op(OP_SUB, 4, 1, 3);
		emit_op(OP_AND, 5, 4, 2);
		emit_op(OP_NOR, 6, 5, 1);
		store_reg(3, 16'h0010, s);
		store_reg(4, 16'h0011, d);
		store_reg(5, 16'h0012, an);
		store_reg(6, 16'h0013, no);
		emit_op(OP_HLT, 0, 0, 0);
		run_test("alu_ops", 0);
	endtask

	task automatic test_shifts();
		int    amts [5] = '{0, 1, 4, 7, 15};
		word_t v;
		word_t sra;
		v = 16'h8421;
		ld_const(1, v);
		for (int i = 0; i < 5; i++) begin
			emit_op(OP_SLL, 2, 1, amts[i]);
			emit_op(OP_SRL, 3, 1, amts[i]);
			emit_op(OP_SRA, 4, 1, amts[i]);
			// Sign fill from the top
			sra = (v >> amts[i]) | (v[15] ? ~(16'hffff >> amts[i]) : 16'h0000);
			store_reg(2, 16'h0020 + 3 * i, v << amts[i]);
			store_reg(3, 16'h0021 + 3 * i, v >> amts[i]);
			store_reg(4, 16'h0022 + 3 * i, sra);
		end
		emit_op(OP_HLT, 0, 0, 0);
		run_test("shifts", 0);
	endtask

	// Load-use pairs, then store and reload
	task automatic test_loads();
		word_t s3;
		word_t s5;
		s3 = fill_word(16'h23) + fill_word(16'h23);
		s5 = fill_word(16'h23) + fill_word(16'h1e);
		ld_const(1, 16'h0020);
		emit_op(OP_LW, 2, 1, 3);
		emit_op(OP_ADD, 3, 2, 2);
		// Offset -2
		emit_op(OP_LW, 4, 1, 4'he);
		emit_op(OP_ADD, 5, 2, 4);
		store_reg(3, 16'h0030, s3);
		store_reg(5, 16'h0031, s5);
		emit_op(OP_LW, 6, 14, 0);
		emit_op(OP_ADD, 7, 6, 3);
		store_reg(7, 16'h0032, s5 + s3);
		emit_op(OP_HLT, 0, 0, 0);
		run_test("loads", 0);
	endtask

	// Marker store survives only when the branch falls through
	task automatic test_branches();
		word_t      av [5] = '{16'h0005, 16'h0003, 16'h0007, 16'h7fff, 16'h8000};
		word_t      bv [5] = '{16'h0005, 16'h0007, 16'h0003, 16'h0001, 16'h0001};
		bit         sub [5] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
		word_t      addr;
		logic [2:0] f;
		for (int k = 0; k < 5; k++) begin
			ld_const(1 + 2 * k, av[k]);
			ld_const(2 + 2 * k, bv[k]);
		end
		ld_const(13, 16'hbeef);
		for (int c = 0; c < 8; c++) begin
			for (int k = 0; k < 5; k++) begin
				addr = 16'h0040 + 5 * c + k;
				f    = arith_flags(av[k], bv[k], sub[k]);
				ld_const(14, addr);
				emit_op(sub[k] ? OP_SUB : OP_ADD, 11, 1 + 2 * k, 2 + 2 * k);
				emit_branch(c, 1);
				emit_op(OP_SW, 13, 14, 0);
				if (!cond_holds(c, f)) begin
					exp_addr.push_back(addr);
					exp_data.push_back(16'hbeef);
				end
			end
		end
		emit_op(OP_HLT, 0, 0, 0);
		run_test("branches", 0);
	endtask

	task automatic test_random_arith();
		word_t a;
		word_t b;
		for (int i = 0; i < 8; i++) begin
			a = take_bits(16);
			b = take_bits(16);
			ld_const(1, a);
			ld_const(2, b);
			emit_op(OP_ADD, 3, 1, 2);
			emit_op(OP_SUB, 4, 1, 2);
			store_reg(3, 16'h0080 + 2 * i, a + b);
			store_reg(4, 16'h0081 + 2 * i, a - b);
		end
		emit_op(OP_HLT, 0, 0, 0);
		run_test("random_arith", 0);
	endtask

	// Writes to r0 are lost, nothing after HLT runs
	task automatic test_halt();
		ld_const(1, 16'h5a5a);
		emit_op(OP_ADD, 0, 1, 1);
		store_reg(0, 16'h0090, 16'h0000);
		emit_op(OP_LLB, 0, 7, 7);
		store_reg(0, 16'h0091, 16'h0000);
		store_reg(1, 16'h0092, 16'h5a5a);
		emit_op(OP_HLT, 0, 0, 0);
		emit_op(OP_SW, 1, 0, 5);
		emit_op(OP_SW, 1, 0, 6);
		run_test("halt", 20);
	endtask

	initial begin
		arst_n = 1'b0;
		for (int i = 0; i < 512; i++) begin
			prog[i] = 16'h0000;
		end
		for (int i = 0; i < 1024; i++) begin
			dmem[i] = fill_word(i);
		end
		test_alu_ops();
		test_shifts();
		test_loads();
		test_branches();
		test_random_arith();
		test_halt();
		$display("Summary: %0d tests passed, %0d tests failed, %0d errors",
			pass_count, fail_count, err_count);
		if (fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== list.f ====
common/cpu_pkg.sv
logic/pipe_reg.sv
logic/fetch_unit.sv
decode/reg_file.sv
decode/decode_unit.sv
logic/alu.sv
logic/hazard_unit.sv
logic/cpu.sv
testbench/tb_cpu.sv
